/* compile.f */
source/dcache_pkg.sv
source/miss_queue.sv
source/mshr_table.sv
source/line_array.sv
source/dcache_top.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the data cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert \
    --top-module dcache_tb \
    --Mdir "$BUILD" -o dcache_sim \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD/dcache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* sim/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*;;

    localparam int PERIOD      = 100;
    localparam int NUM_CYCLES  = 1500;
    localparam int QUEUE_DEPTH = 4;
    localparam int WATCHDOG_NS = (NUM_CYCLES * 4 + 200) * PERIOD;

    logic                           clock;
    logic                           reset;
    load_req_t                      load;
    store_req_t                     store;
    mem_resp_t                      mem_resp;
    logic                           load_accept;
    logic                           store_accept;
    word_t                          load_data;
    logic                           load_data_valid;
    load_result_t [QUEUE_DEPTH-1:0] load_results;
    mem_req_t                       mem_req;

    // memory model state
    mem_tag_t txn_tag_r;
    mem_tag_t data_tag_r;
    block_t   data_r;
    mem_tag_t cur_tag;
    mem_tag_t fill_tag_q [$];
    addr_t    fill_addr_q [$];
    int       fill_due_q [$];
    word_t    mem_img [addr_t];
    word_t    shadow [addr_t];

    // deferred load bookkeeping, indexed by lq_idx
    logic [7:0] busy;
    word_t      expected [8];
    logic       load_taken;
    logic       store_taken;
    logic       stopping;
    int         cycle;
    int         errors;
    int         blocked;
    int         quiet;

    assign mem_resp = '{transaction_tag: txn_tag_r, data_tag: data_tag_r, data: data_r};

    dcache_top #(
        .LINES      (16),
        .MSHRS      (2),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut (
        .clock          (clock),
        .reset          (reset),
        .load           (load),
        .store          (store),
        .mem_resp       (mem_resp),
        .load_accept    (load_accept),
        .store_accept   (store_accept),
        .load_data      (load_data),
        .load_data_valid(load_data_valid),
        .load_results   (load_results),
        .mem_req        (mem_req)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // initial memory contents depend on every address bit
    function automatic word_t pattern(addr_t wa);
        return (wa * 32'h9e3779b1) ^ 32'h3c5a0f17;
    endfunction

    function automatic word_t shadow_word(addr_t byte_addr);
        addr_t wa;
        wa = byte_addr >> 2;
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return pattern(wa);
    endfunction

    function automatic word_t mem_word(addr_t wa);
        if (mem_img.exists(wa)) begin
            return mem_img[wa];
        end
        return pattern(wa);
    endfunction

    function automatic word_t lane_write(word_t old, mem_size_e sz, logic [1:0] off, word_t v);
        word_t w;
        w = old;
        case (sz)
            size_byte: w[{off, 3'b000} +: 8] = v[7:0];
            size_half: w[{off[1], 4'b0000} +: 16] = v[15:0];
            default:   w = v;
        endcase
        return w;
    endfunction

    function automatic addr_t random_addr(mem_size_e sz);
        addr_t a;
        a = 32'h1000 + ($urandom % 4) * 128 + ($urandom % 4) * 8 + ($urandom % 8);
        if (sz == size_half) begin
            a[0] = 1'b0;
        end else if (sz == size_word) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    function automatic mem_size_e random_size();
        case ($urandom % 3)
            0:       return size_byte;
            1:       return size_half;
            default: return size_word;
        endcase
    endfunction

    function automatic int free_lq_idx();
        int start;
        start = int'($urandom % 8);
        for (int k = 0; k < 8; k++) begin
            if (!busy[(start + k) % 8]) begin
                return (start + k) % 8;
            end
        end
        return -1;
    endfunction

    // stimulus and memory answers, driven on the rising edge
    always @(posedge clock) begin
        int idx;
        mem_size_e sz;
        if (!reset) begin
            cycle = cycle + 1;
            if (!load.valid || load_taken) begin
                idx = free_lq_idx();
                if (!stopping && idx >= 0 && $urandom % 3 != 0) begin
                    load <= '{valid: 1'b1, addr: random_addr(size_word), size: size_word,
                              lq_idx: lq_idx_t'(idx)};
                end else begin
                    load <= '0;
                end
            end
            if (!store.valid || store_taken) begin
                sz = random_size();
                if (!stopping && $urandom % 2 == 0) begin
                    store <= '{valid: 1'b1, addr: random_addr(sz), size: sz, data: $urandom};
                end else begin
                    store <= '0;
                end
            end
            load_taken  = 1'b0;
            store_taken = 1'b0;
            txn_tag_r  <= cur_tag;
            data_tag_r <= '0;
            for (int k = 0; k < fill_due_q.size(); k++) begin
                if (fill_due_q[k] <= cycle) begin
                    data_tag_r <= fill_tag_q[k];
                    data_r     <= {mem_word((fill_addr_q[k] >> 2) + 1),
                                   mem_word(fill_addr_q[k] >> 2)};
                    fill_tag_q.delete(k);
                    fill_addr_q.delete(k);
                    fill_due_q.delete(k);
                    break;
                end
            end
        end
    end

    // checks, sampled at the falling edge while everything is stable
    always @(negedge clock) begin
        lq_idx_t idx;
        if (!reset) begin
            if (load.valid && load_data_valid) begin
                assert (load_data == shadow_word(load.addr)) else begin
                    errors++;
                    $display("FAIL %0t load_data got %h expected %h", $time, load_data,
                             shadow_word(load.addr));
                end
            end
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (load_results[i].valid) begin
                    idx = load_results[i].lq_idx;
                    assert (busy[idx]) else begin
                        errors++;
                        $display("result returned for load index %0d that was not waiting",
                                 idx);
                    end
                    assert (load_results[i].data == expected[idx]) else begin
                        errors++;
                        $display("FAIL %0t load_results[%0d].data got %h expected %h", $time,
                                 i, load_results[i].data, expected[idx]);
                    end
                    busy[idx] = 1'b0;
                end
            end
            if (load.valid && load_accept && !load_data_valid) begin
                busy[load.lq_idx]     = 1'b1;
                expected[load.lq_idx] = shadow_word(load.addr);
            end
            if (load.valid && !load_accept) begin
                blocked++;
            end
            load_taken = load.valid && load_accept;
            if (mem_req.command == mem_store) begin
                for (int w = 0; w < 2; w++) begin
                    assert (mem_req.data[w] == shadow_word(mem_req.addr + 4 * w)) else begin
                        errors++;
                        $display("FAIL %0t mem_req.data[%0d] got %h expected %h", $time, w,
                                 mem_req.data[w], shadow_word(mem_req.addr + 4 * w));
                    end
                    mem_img[(mem_req.addr >> 2) + w] = mem_req.data[w];
                end
            end
            if (mem_req.command == mem_load) begin
                foreach (fill_addr_q[k]) begin
                    assert (fill_addr_q[k] != mem_req.addr) else begin
                        errors++;
                        $display("second memory load for block %h while one is in flight",
                                 mem_req.addr);
                    end
                end
                fill_tag_q.push_back(cur_tag);
                fill_addr_q.push_back(mem_req.addr);
                fill_due_q.push_back(cycle + 3 + int'($urandom % 4));
                cur_tag = (cur_tag == 4'd15) ? 4'd1 : cur_tag + 4'd1;
            end
            if (store.valid && store_accept) begin
                shadow[store.addr >> 2] = lane_write(shadow_word(store.addr), store.size,
                                                     store.addr[1:0], store.data);
            end
            store_taken = store.valid && store_accept;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h52dd));
        reset       <= 1'b1;
        load        <= '0;
        store       <= '0;
        txn_tag_r   <= '0;
        data_tag_r  <= '0;
        data_r      <= '0;
        stopping    <= 1'b0;
        cur_tag     = 4'd1;
        busy        = '0;
        load_taken  = 1'b0;
        store_taken = 1'b0;
        cycle       = 0;
        errors      = 0;
        blocked     = 0;
        quiet       = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        repeat (NUM_CYCLES) @(posedge clock);
        stopping <= 1'b1;
        // drain until nothing is outstanding for a while
        while (quiet < 10) begin
            @(posedge clock);
            if (busy != 0 || fill_due_q.size() != 0 || load.valid || store.valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (blocked == 0) begin
            errors++;
            $display("no miss was ever held back by full MSHRs or queues");
        end
        $display("errors: %0d, back-pressure cycles: %0d", errors, blocked);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim/dcache_asserts.sv */
`timescale 1ns/1ps

module dcache_asserts import dcache_pkg::*; #(
    parameter int MSHRS       = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           load_accept,
    input  logic                           store_accept,
    input  logic                           load_data_valid,
    input  load_result_t [QUEUE_DEPTH-1:0] load_results,
    input  mem_req_t                       mem_req,
    input  mshr_state_e                    state      [MSHRS],
    input  logic [31:BLOCK_OFFSET_BITS]    block_addr [MSHRS]
);

    // outputs stay idle while reset holds
    assert property (@(posedge clock) reset && $past(reset) |->
            mem_req.command == mem_none && !load_accept && !store_accept
            && !load_data_valid && load_results == '0)
        else $error("outputs not idle during reset");

    assert property (@(posedge clock) disable iff (reset) !$isunknown(mem_req.command))
        else $error("memory command is unknown");

    // results of one fill never share a load index
    for (genvar a = 0; a < QUEUE_DEPTH; a++) begin : g_result
        for (genvar b = a + 1; b < QUEUE_DEPTH; b++) begin : g_other
            assert property (@(posedge clock) disable iff (reset)
                    !(load_results[a].valid && load_results[b].valid
                      && load_results[a].lq_idx == load_results[b].lq_idx))
                else $error("results %0d and %0d carry the same load index", a, b);
        end
    end

    // one block never owns two MSHRs
    for (genvar i = 0; i < MSHRS; i++) begin : g_first
        for (genvar j = i + 1; j < MSHRS; j++) begin : g_second
            assert property (@(posedge clock) disable iff (reset)
                    !(state[i] != mshr_invalid && state[j] != mshr_invalid
                      && block_addr[i] == block_addr[j]))
                else $error("MSHR %0d and %0d track the same block", i, j);
        end
    end

endmodule

bind dcache_top dcache_asserts #(
    .MSHRS      (MSHRS),
    .QUEUE_DEPTH(QUEUE_DEPTH)
) u_asserts (
    .clock          (clock),
    .reset          (reset),
    .load_accept    (load_accept),
    .store_accept   (store_accept),
    .load_data_valid(load_data_valid),
    .load_results   (load_results),
    .mem_req        (mem_req),
    .state          (u_mshrs.state),
    .block_addr     (u_mshrs.block_addr)
);

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int LINES       = 16,
    parameter int MSHRS       = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  load_req_t                      load,
    input  store_req_t                     store,
    input  mem_resp_t                      mem_resp,
    output logic                           load_accept,
    output logic                           store_accept,
    output word_t                          load_data,
    output logic                           load_data_valid,
    output load_result_t [QUEUE_DEPTH-1:0] load_results,
    output mem_req_t                       mem_req
);

    logic                          load_hit;
    logic                          store_hit;
    logic                          evicting;
    logic                          load_accept_miss;
    logic                          store_accept_miss;
    mem_req_t                      table_mem_req;
    fill_t                         fill;
    queued_req_t [QUEUE_DEPTH-1:0] fill_reqs;
    logic [QUEUE_DEPTH-1:0]        fill_valid;

    line_array #(
        .LINES      (LINES),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_lines (
        .clock          (clock),
        .reset          (reset),
        .load           (load),
        .store          (store),
        .fill           (fill),
        .fill_reqs      (fill_reqs),
        .fill_valid     (fill_valid),
        .mem_load       (table_mem_req),
        .load_hit       (load_hit),
        .store_hit      (store_hit),
        .load_data_valid(load_data_valid),
        .load_data      (load_data),
        .load_results   (load_results),
        .evicting       (evicting),
        .mem_req        (mem_req)
    );

    mshr_table #(
        .MSHRS      (MSHRS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_mshrs (
        .clock            (clock),
        .reset            (reset),
        .load             (load),
        .store            (store),
        .load_hit         (load_hit),
        .store_hit        (store_hit),
        .evicting         (evicting),
        .mem_resp         (mem_resp),
        .load_accept_miss (load_accept_miss),
        .store_accept_miss(store_accept_miss),
        .mem_load         (table_mem_req),
        .fill             (fill),
        .fill_reqs        (fill_reqs),
        .fill_valid       (fill_valid)
    );

    // a hit is always taken, a miss only if an MSHR queue has room
    assign load_accept  = load_hit || load_accept_miss;
    assign store_accept = store_hit || store_accept_miss;

endmodule

/* source/line_array.sv */
`timescale 1ns/1ps

module line_array import dcache_pkg::*; #(
    parameter int LINES       = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  load_req_t                      load,
    input  store_req_t                     store,
    input  fill_t                          fill,
    input  queued_req_t [QUEUE_DEPTH-1:0]  fill_reqs,
    input  logic [QUEUE_DEPTH-1:0]         fill_valid,
    input  mem_req_t                       mem_load,
    output logic                           load_hit,
    output logic                           store_hit,
    output logic                           load_data_valid,
    output word_t                          load_data,
    output load_result_t [QUEUE_DEPTH-1:0] load_results,
    output logic                           evicting,
    output mem_req_t                       mem_req
);

    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TAG_BITS   = 32 - BLOCK_OFFSET_BITS - INDEX_BITS;

    logic [LINES-1:0]    valid;
    logic [LINES-1:0]    dirty;
    logic [LINES-1:0]    next_valid;
    logic [LINES-1:0]    next_dirty;
    logic [TAG_BITS-1:0] tags      [LINES];
    logic [TAG_BITS-1:0] next_tags [LINES];
    block_t              data      [LINES];
    block_t              next_data [LINES];

    logic [INDEX_BITS-1:0] fill_index;
    logic [INDEX_BITS-1:0] load_index;
    logic [INDEX_BITS-1:0] store_index;
    logic [TAG_BITS-1:0]   fill_tag;
    logic [TAG_BITS-1:0]   load_tag;
    logic [TAG_BITS-1:0]   store_tag;

    assign fill_index  = fill.block_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign fill_tag    = fill.block_addr[31 -: TAG_BITS];
    assign load_index  = load.addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign load_tag    = load.addr[31 -: TAG_BITS];
    assign store_index = store.addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign store_tag   = store.addr[31 -: TAG_BITS];

    // byte, half or word written at its offset
    function automatic block_t merge_store(block_t blk, mem_size_e size,
                                           logic [BLOCK_OFFSET_BITS-1:0] offset, word_t value);
        logic [63:0] bits;
        bits = blk;
        case (size)
            size_byte: bits[{offset, 3'b000} +: 8]       = value[7:0];
            size_half: bits[{offset[2:1], 4'b0000} +: 16] = value[15:0];
            default:   bits[{offset[2], 5'b00000} +: 32] = value;
        endcase
        return bits;
    endfunction

    assign evicting = fill.valid && valid[fill_index] && dirty[fill_index];

    // victim write-back takes the port, otherwise the table's load
    always_comb begin
        mem_req = mem_load;
        if (evicting) begin
            mem_req.command = mem_store;
            mem_req.addr    = {tags[fill_index], fill_index, {BLOCK_OFFSET_BITS{1'b0}}};
            mem_req.data    = data[fill_index];
        end
    end

    always_comb begin
        next_valid   = valid;
        next_dirty   = dirty;
        next_tags    = tags;
        next_data    = data;
        load_results = '0;

        // install first so same-cycle lookups see the new block
        if (fill.valid) begin
            next_valid[fill_index] = 1'b1;
            next_dirty[fill_index] = 1'b0;
            next_tags[fill_index]  = fill_tag;
            next_data[fill_index]  = fill.data;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (fill_valid[i] && fill_reqs[i].kind == kind_store) begin
                    next_data[fill_index] = merge_store(next_data[fill_index], fill_reqs[i].size,
                                                        fill_reqs[i].offset, fill_reqs[i].data);
                    next_dirty[fill_index] = 1'b1;
                end else if (fill_valid[i]) begin
                    load_results[i].valid  = 1'b1;
                    load_results[i].lq_idx = fill_reqs[i].lq_idx;
                    load_results[i].data   = next_data[fill_index][fill_reqs[i].offset[2]];
                end
            end
        end

        load_hit        = load.valid && next_valid[load_index] && next_tags[load_index] == load_tag;
        load_data_valid = load_hit;
        load_data       = next_data[load_index][load.addr[2]];

        store_hit = store.valid && next_valid[store_index] && next_tags[store_index] == store_tag;
        if (store_hit) begin
            next_data[store_index]  = merge_store(next_data[store_index], store.size,
                                                  store.addr[BLOCK_OFFSET_BITS-1:0], store.data);
            next_dirty[store_index] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            valid <= next_valid;
            dirty <= next_dirty;
        end
    end

    always_ff @(posedge clock) begin
        tags <= next_tags;
        data <= next_data;
    end

endmodule

/* source/mshr_table.sv */
`timescale 1ns/1ps

module mshr_table import dcache_pkg::*; #(
    parameter int MSHRS       = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  load_req_t                     load,
    input  store_req_t                    store,
    input  logic                          load_hit,
    input  logic                          store_hit,
    input  logic                          evicting,
    input  mem_resp_t                     mem_resp,
    output logic                          load_accept_miss,
    output logic                          store_accept_miss,
    output mem_req_t                      mem_load,
    output fill_t                         fill,
    output queued_req_t [QUEUE_DEPTH-1:0] fill_reqs,
    output logic [QUEUE_DEPTH-1:0]        fill_valid
);

    localparam int IDX_BITS = (MSHRS > 1) ? $clog2(MSHRS) : 1;

    // entry table
    mshr_state_e                 state      [MSHRS];
    logic [31:BLOCK_OFFSET_BITS] block_addr [MSHRS];
    mem_tag_t                    txn_tag    [MSHRS];

    logic [MSHRS-1:0]            fill_hit;
    logic [MSHRS-1:0]            live;
    logic [MSHRS-1:0]            alloc;
    logic [MSHRS-1:0]            issue;
    logic [31:BLOCK_OFFSET_BITS] alloc_addr [MSHRS];

    // slot 0 is the load port, slot 1 the store port
    logic [1:0]                         miss;
    logic [1:0][31:BLOCK_OFFSET_BITS]   miss_block;
    queued_req_t [1:0]                  miss_req;
    logic [1:0]                         routed;
    logic [1:0][IDX_BITS-1:0]           target;

    logic [1:0]                    push_valid  [MSHRS];
    queued_req_t [1:0]             push_req    [MSHRS];
    logic [1:0]                    push_accept [MSHRS];
    queued_req_t [QUEUE_DEPTH-1:0] flush_req   [MSHRS];
    logic [QUEUE_DEPTH-1:0]        flush_valid [MSHRS];

    for (genvar j = 0; j < MSHRS; j++) begin : g_queue
        miss_queue #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) u_queue (
            .clock      (clock),
            .reset      (reset),
            .push_valid (push_valid[j]),
            .push_req   (push_req[j]),
            .flush      (fill_hit[j]),
            .push_accept(push_accept[j]),
            .flush_req  (flush_req[j]),
            .flush_valid(flush_valid[j])
        );
    end

    always_comb begin
        miss[0]       = load.valid && !load_hit;
        miss[1]       = store.valid && !store_hit;
        miss_block[0] = load.addr[31:BLOCK_OFFSET_BITS];
        miss_block[1] = store.addr[31:BLOCK_OFFSET_BITS];
        miss_req[0]   = '{kind: kind_load, size: load.size, data: '0,
                          offset: load.addr[BLOCK_OFFSET_BITS-1:0], lq_idx: load.lq_idx};
        miss_req[1]   = '{kind: kind_store, size: store.size, data: store.data,
                          offset: store.addr[BLOCK_OFFSET_BITS-1:0], lq_idx: '0};
    end

    // fill detection, the entry retires in this cycle
    always_comb begin
        fill     = '0;
        fill_hit = '0;
        for (int j = 0; j < MSHRS; j++) begin
            if (state[j] == mshr_wait_data && mem_resp.data_tag != '0
                    && txn_tag[j] == mem_resp.data_tag) begin
                fill_hit[j]     = 1'b1;
                fill.valid      = 1'b1;
                fill.block_addr = block_addr[j];
                fill.data       = mem_resp.data;
            end
        end
        for (int j = 0; j < MSHRS; j++) begin
            live[j] = state[j] != mshr_invalid && !fill_hit[j];
        end
    end

    always_comb begin
        fill_reqs  = '0;
        fill_valid = '0;
        for (int j = 0; j < MSHRS; j++) begin
            if (fill_hit[j]) begin
                fill_reqs  = flush_req[j];
                fill_valid = flush_valid[j];
            end
        end
    end

    // match, else take the lowest free entry
    always_comb begin
        alloc  = '0;
        routed = '0;
        target = '0;
        for (int j = 0; j < MSHRS; j++) begin
            alloc_addr[j] = block_addr[j];
        end
        for (int s = 0; s < 2; s++) begin
            // alloc covers an entry the load slot opened this cycle
            for (int j = 0; j < MSHRS; j++) begin
                if (miss[s] && (live[j] || alloc[j]) && alloc_addr[j] == miss_block[s]) begin
                    routed[s] = 1'b1;
                    target[s] = IDX_BITS'(j);
                end
            end
            for (int j = 0; j < MSHRS; j++) begin
                if (miss[s] && !routed[s] && state[j] == mshr_invalid && !alloc[j]) begin
                    routed[s]     = 1'b1;
                    target[s]     = IDX_BITS'(j);
                    alloc[j]      = 1'b1;
                    alloc_addr[j] = miss_block[s];
                end
            end
        end
        for (int j = 0; j < MSHRS; j++) begin
            for (int s = 0; s < 2; s++) begin
                push_valid[j][s] = routed[s] && target[s] == IDX_BITS'(j);
            end
            push_req[j] = miss_req;
        end
    end

    assign load_accept_miss  = routed[0] && push_accept[target[0]][0];
    assign store_accept_miss = routed[1] && push_accept[target[1]][1];

    // lowest pending entry owns the memory port
    always_comb begin
        logic picked;
        picked           = 1'b0;
        issue            = '0;
        mem_load         = '0;
        mem_load.command = mem_none;
        for (int j = 0; j < MSHRS; j++) begin
            if (!picked && state[j] == mshr_pending) begin
                picked = 1'b1;
                if (!evicting) begin
                    issue[j]         = 1'b1;
                    mem_load.command = dcache_pkg::mem_load;
                    mem_load.addr    = {block_addr[j], {BLOCK_OFFSET_BITS{1'b0}}};
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 0; j < MSHRS; j++) begin
            if (reset || fill_hit[j]) begin
                state[j] <= mshr_invalid;
            end else if (issue[j] && mem_resp.transaction_tag != '0) begin
                state[j] <= mshr_wait_data;
            end else if (alloc[j]) begin
                state[j] <= mshr_pending;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 0; j < MSHRS; j++) begin
            if (alloc[j]) begin
                block_addr[j] <= alloc_addr[j];
            end
            if (issue[j]) begin
                txn_tag[j] <= mem_resp.transaction_tag;
            end
        end
    end

endmodule

/* source/miss_queue.sv */
`timescale 1ns/1ps

module miss_queue import dcache_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [1:0]                     push_valid,
    input  queued_req_t [1:0]              push_req,
    input  logic                           flush,
    output logic [1:0]                     push_accept,
    output queued_req_t [QUEUE_DEPTH-1:0]  flush_req,
    output logic [QUEUE_DEPTH-1:0]         flush_valid
);

    localparam int PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    queued_req_t [QUEUE_DEPTH-1:0] entries;
    logic [PTR_BITS-1:0]           head;
    logic [PTR_BITS-1:0]           tail;
    logic [PTR_BITS-1:0]           next_tail;
    logic [1:0][PTR_BITS-1:0]      slot_ptr;
    logic [COUNT_BITS-1:0]         count;
    logic [COUNT_BITS-1:0]         next_count;

    function automatic logic [PTR_BITS-1:0] ptr_inc(logic [PTR_BITS-1:0] ptr);
        if (int'(ptr) == QUEUE_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // load slot first, then store slot
    always_comb begin
        push_accept = '0;
        slot_ptr    = '0;
        next_tail   = tail;
        next_count  = count;
        for (int s = 0; s < 2; s++) begin
            slot_ptr[s] = next_tail;
            if (push_valid[s] && !flush && int'(next_count) < QUEUE_DEPTH) begin
                push_accept[s] = 1'b1;
                next_tail      = ptr_inc(next_tail);
                next_count     = next_count + 1'b1;
            end
        end
    end

    // oldest entry lands in slot 0
    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            flush_req[i]   = entries[(int'(head) + i) % QUEUE_DEPTH];
            flush_valid[i] = flush && (i < int'(count));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // empty again, restart at the current tail
            head  <= tail;
            count <= '0;
        end else begin
            tail  <= next_tail;
            count <= next_count;
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < 2; s++) begin
            if (push_accept[s]) begin
                entries[slot_ptr[s]] <= push_req[s];
            end
        end
    end

endmodule

/* source/dcache_pkg.sv */
package dcache_pkg;

    localparam int BLOCK_OFFSET_BITS = 3;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // two words per line, word 0 at the low address
    typedef word_t [1:0] block_t;

    // zero means no transaction
    typedef logic [3:0] mem_tag_t;

    typedef logic [2:0] lq_idx_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_command_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef enum logic {
        kind_load,
        kind_store
    } req_kind_e;

    typedef enum logic [1:0] {
        mshr_invalid,
        mshr_pending,
        mshr_wait_data
    } mshr_state_e;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_e size;
        lq_idx_t   lq_idx;
    } load_req_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_e size;
        word_t     data;
    } store_req_t;

    // one deferred request parked behind an MSHR
    typedef struct packed {
        req_kind_e                    kind;
        mem_size_e                    size;
        word_t                        data;
        logic [BLOCK_OFFSET_BITS-1:0] offset;
        lq_idx_t                      lq_idx;
    } queued_req_t;

    typedef struct packed {
        logic    valid;
        lq_idx_t lq_idx;
        word_t   data;
    } load_result_t;

    typedef struct packed {
        mem_command_e command;
        addr_t        addr;
        block_t       data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t transaction_tag;
        mem_tag_t data_tag;
        block_t   data;
    } mem_resp_t;

    typedef struct packed {
        logic                        valid;
        logic [31:BLOCK_OFFSET_BITS] block_addr;
        block_t                      data;
    } fill_t;

endpackage
